//--- source/f100l_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the reduced F100-L core.
// Opcodes, field widths, cr flag positions, the sequencer
// state type and the instruction word decodings. Files refer
// to these by scoped names.
////////////////////////////////////////////////////////////

package f100l_pkg;

  localparam int word_width     = 16;
  localparam int sign_bit       = word_width - 1;
  localparam int ram_depth      = 2048;
  localparam int ram_addr_width = 11;
  localparam int op_width       = 4;
  localparam int group_width    = 6;

  // Condition register bit positions
  localparam int flag_c_bit = 4;
  localparam int flag_s_bit = 3;
  localparam int flag_v_bit = 2;
  localparam int flag_z_bit = 1;

  // Upper six bits of the halt word
  localparam logic [group_width-1:0] halt_group = 6'b000001;

  typedef logic [word_width-1:0] word_t;

  typedef enum logic [op_width-1:0] {
    op_sto = 4'h4,
    op_lda = 4'h8,
    op_add = 4'h9,
    op_sub = 4'ha,
    op_and = 4'hc,
    op_neq = 4'hd,
    op_jmp = 4'hf
  } op_t;

  typedef struct packed {
    op_t                       op;
    logic                      indirect;
    logic [ram_addr_width-1:0] addr;
  } alu_form_t;

  typedef struct packed {
    logic [group_width-1:0]            group;
    logic [word_width-group_width-1:0] remainder;
  } ctrl_form_t;

  typedef union packed {
    alu_form_t  alu_form;
    ctrl_form_t ctrl_form;
  } instr_t;

  typedef enum logic [3:0] {
    reset_idle,
    fetch_req,
    fetch_wait,
    decode,
    imm_req,
    imm_wait,
    operand_req,
    operand_wait,
    execute,
    store_req,
    halted
  } seq_state_t;

endpackage

//--- source/mem_bus_if.sv
////////////////////////////////////////////////////////////
// Word memory bus between the sequencer and the RAM.
// bus_enable is a one-cycle strobe. Reads return data in the
// following cycle and hold it until the next read.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface mem_bus_if;

  f100l_pkg::word_t address;
  f100l_pkg::word_t write_data;
  f100l_pkg::word_t read_data;
  logic             bus_enable;
  logic             write_enable;

  modport cpu (
    output address,
    output write_data,
    output bus_enable,
    output write_enable,
    input  read_data
  );

  modport ram (
    input  address,
    input  write_data,
    input  bus_enable,
    input  write_enable,
    output read_data
  );

endinterface

//--- source/f100l_alu.sv
////////////////////////////////////////////////////////////
// Combinational ALU for the F100-L core.
// Produces a 17-bit result (bit 16 is carry or borrow) and
// the updated condition register for the given opcode.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module f100l_alu (
  input  f100l_pkg::op_t                    op,
  input  f100l_pkg::word_t                  operand,
  input  f100l_pkg::word_t                  acc,
  input  f100l_pkg::word_t                  cr_in,
  output logic [f100l_pkg::word_width:0]    result,
  output f100l_pkg::word_t                  cr_out
);

  logic updates_flags;

  always_comb
  begin
    result        = {1'b0, acc};
    cr_out        = cr_in;
    updates_flags = 1'b1;

    case (op)
      f100l_pkg::op_lda: result = {1'b0, operand};
      f100l_pkg::op_add: result = {1'b0, operand} + {1'b0, acc};
      // Operand minus accumulator, bit 16 ends up as the borrow
      f100l_pkg::op_sub: result = {1'b0, operand} - {1'b0, acc};
      f100l_pkg::op_and: result = {1'b0, operand & acc};
      f100l_pkg::op_neq: result = {1'b0, operand ^ acc};
      default:           updates_flags = 1'b0;
    endcase

    if (updates_flags)
    begin
      cr_out[f100l_pkg::flag_c_bit] = result[f100l_pkg::word_width];
      cr_out[f100l_pkg::flag_s_bit] = result[f100l_pkg::sign_bit];
      cr_out[f100l_pkg::flag_z_bit] = (result[f100l_pkg::sign_bit:0] == '0);
    end

    // Signed overflow, other ops leave V alone
    if (op == f100l_pkg::op_add)
    begin
      cr_out[f100l_pkg::flag_v_bit] =
        (acc[f100l_pkg::sign_bit] == operand[f100l_pkg::sign_bit]) &&
        (result[f100l_pkg::sign_bit] != acc[f100l_pkg::sign_bit]);
    end
    else if (op == f100l_pkg::op_sub)
    begin
      cr_out[f100l_pkg::flag_v_bit] =
        (acc[f100l_pkg::sign_bit] != operand[f100l_pkg::sign_bit]) &&
        (result[f100l_pkg::sign_bit] == acc[f100l_pkg::sign_bit]);
    end
  end

endmodule

//--- source/f100l_ram.sv
////////////////////////////////////////////////////////////
// Program and data RAM for the F100-L core.
// Registered read on the CPU port. While button_reset is
// low only the load port may write, otherwise only the CPU.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module f100l_ram (
  input  logic             raw_clk,
  input  logic             button_reset,
  mem_bus_if.ram           mem,
  input  logic             load_strobe,
  input  f100l_pkg::word_t load_address,
  input  f100l_pkg::word_t load_data
);

  f100l_pkg::word_t ram [f100l_pkg::ram_depth];

  logic                                wr_en;
  logic [f100l_pkg::ram_addr_width-1:0] wr_addr;
  f100l_pkg::word_t                    wr_data;

  // Load port owns the write path during reset
  always_comb
  begin
    if (!button_reset)
    begin
      wr_en   = load_strobe;
      wr_addr = load_address[f100l_pkg::ram_addr_width-1:0];
      wr_data = load_data;
    end
    else
    begin
      wr_en   = mem.bus_enable && mem.write_enable;
      wr_addr = mem.address[f100l_pkg::ram_addr_width-1:0];
      wr_data = mem.write_data;
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (wr_en)
      ram[wr_addr] <= wr_data;
    if (mem.bus_enable && !mem.write_enable)
      mem.read_data <= ram[mem.address[f100l_pkg::ram_addr_width-1:0]];
  end

endmodule

//--- source/f100l_sequencer.sv
////////////////////////////////////////////////////////////
// Multi-cycle instruction sequencer for the F100-L core.
// Fetches and decodes one instruction at a time, reads the
// operand, executes through the ALU and issues stores.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module f100l_sequencer (
  input  logic                           raw_clk,
  input  logic                           button_reset,
  mem_bus_if.cpu                         mem,
  output f100l_pkg::op_t                 alu_op,
  output f100l_pkg::word_t               alu_operand,
  input  logic [f100l_pkg::word_width:0] alu_result,
  input  f100l_pkg::word_t               alu_cr,
  output f100l_pkg::word_t               accum,
  output f100l_pkg::word_t               cr,
  output logic                           halted,
  output logic                           store_strobe
);

  f100l_pkg::seq_state_t state;
  f100l_pkg::instr_t     ir;
  f100l_pkg::word_t      pc;
  f100l_pkg::word_t      ea;
  f100l_pkg::word_t      operand;

  logic is_halt;
  logic is_known;
  logic is_imm;
  logic is_jmp;
  logic writes_acc;

  assign is_halt = (ir.ctrl_form.group == f100l_pkg::halt_group);
  assign is_imm  = (ir.alu_form.addr == '0);
  assign is_jmp  = (ir.alu_form.op == f100l_pkg::op_jmp);

  // Pointer forms are not supported, such words are skipped
  assign is_known = !ir.alu_form.indirect &&
                    (ir.alu_form.op inside {f100l_pkg::op_lda, f100l_pkg::op_sto,
                                            f100l_pkg::op_add, f100l_pkg::op_sub,
                                            f100l_pkg::op_and, f100l_pkg::op_neq,
                                            f100l_pkg::op_jmp});

  assign writes_acc = ir.alu_form.op inside {f100l_pkg::op_lda, f100l_pkg::op_add,
                                             f100l_pkg::op_sub, f100l_pkg::op_and,
                                             f100l_pkg::op_neq};

  assign alu_op       = ir.alu_form.op;
  assign alu_operand  = operand;
  assign halted       = (state == f100l_pkg::halted);
  assign store_strobe = (state == f100l_pkg::store_req);

  // Bus strobes follow the request states directly
  always_comb
  begin
    mem.bus_enable   = 1'b0;
    mem.write_enable = 1'b0;
    mem.address      = ea;
    case (state)
      f100l_pkg::fetch_req:
      begin
        mem.bus_enable = 1'b1;
        mem.address    = pc;
      end
      f100l_pkg::imm_req, f100l_pkg::operand_req:
        mem.bus_enable = 1'b1;
      f100l_pkg::store_req:
      begin
        mem.bus_enable   = 1'b1;
        mem.write_enable = 1'b1;
      end
      default:
        mem.bus_enable = 1'b0;
    endcase
  end

  assign mem.write_data = accum;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= f100l_pkg::reset_idle;
      pc    <= '0;
      accum <= '0;
      cr    <= '0;
    end
    else
    begin
      case (state)
        f100l_pkg::reset_idle:
          state <= f100l_pkg::fetch_req;
        f100l_pkg::fetch_req:
        begin
          pc    <= pc + 1'b1;
          state <= f100l_pkg::fetch_wait;
        end
        f100l_pkg::fetch_wait:
          state <= f100l_pkg::decode;
        f100l_pkg::decode:
        begin
          if (is_halt)
            state <= f100l_pkg::halted;
          else if (!is_known)
            state <= f100l_pkg::fetch_req;
          else if (is_imm)
            state <= f100l_pkg::imm_req;
          else if (is_jmp)
            state <= f100l_pkg::execute;
          else
            state <= f100l_pkg::operand_req;
        end
        f100l_pkg::imm_req:
        begin
          // Step over the literal word
          pc    <= pc + 1'b1;
          state <= f100l_pkg::imm_wait;
        end
        f100l_pkg::operand_req:
          state <= f100l_pkg::operand_wait;
        f100l_pkg::imm_wait, f100l_pkg::operand_wait:
          state <= f100l_pkg::execute;
        f100l_pkg::execute:
        begin
          cr <= alu_cr;
          if (writes_acc)
            accum <= alu_result[f100l_pkg::sign_bit:0];
          if (is_jmp)
            pc <= is_imm ? operand : ea;
          if (ir.alu_form.op == f100l_pkg::op_sto)
            state <= f100l_pkg::store_req;
          else
            state <= f100l_pkg::fetch_req;
        end
        f100l_pkg::store_req:
          state <= f100l_pkg::fetch_req;
        f100l_pkg::halted:
          state <= f100l_pkg::halted;
        default:
          state <= f100l_pkg::reset_idle;
      endcase
    end
  end

  // Instruction, effective address and operand registers
  always_ff @(posedge raw_clk)
  begin
    if (state == f100l_pkg::fetch_wait)
      ir <= mem.read_data;
    if (state == f100l_pkg::decode)
      ea <= is_imm ? pc : f100l_pkg::word_t'(ir.alu_form.addr);
    if (state == f100l_pkg::imm_wait || state == f100l_pkg::operand_wait)
      operand <= mem.read_data;
  end

endmodule

//--- source/f100l_top.sv
////////////////////////////////////////////////////////////
// Top level of the reduced F100-L core.
// Load the RAM through the load port while button_reset is
// low, release reset and watch store_strobe and halted.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module f100l_top (
  input  logic             raw_clk,
  input  logic             button_reset,
  input  logic             load_strobe,
  input  f100l_pkg::word_t load_address,
  input  f100l_pkg::word_t load_data,
  output logic             store_strobe,
  output f100l_pkg::word_t store_address,
  output f100l_pkg::word_t store_data,
  output f100l_pkg::word_t accum,
  output f100l_pkg::word_t cr,
  output logic             halted
);

  mem_bus_if mem_bus ();

  f100l_pkg::op_t                 alu_op;
  f100l_pkg::word_t               alu_operand;
  logic [f100l_pkg::word_width:0] alu_result;
  f100l_pkg::word_t               alu_cr;

  f100l_sequencer sequencer_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem          (mem_bus),
    .alu_op       (alu_op),
    .alu_operand  (alu_operand),
    .alu_result   (alu_result),
    .alu_cr       (alu_cr),
    .accum        (accum),
    .cr           (cr),
    .halted       (halted),
    .store_strobe (store_strobe)
  );

  f100l_alu alu_i (
    .op      (alu_op),
    .operand (alu_operand),
    .acc     (accum),
    .cr_in   (cr),
    .result  (alu_result),
    .cr_out  (alu_cr)
  );

  f100l_ram ram_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem          (mem_bus),
    .load_strobe  (load_strobe),
    .load_address (load_address),
    .load_data    (load_data)
  );

  assign store_address = mem_bus.address;
  assign store_data    = mem_bus.write_data;

endmodule

//--- include/f100l_tb_model.svh
////////////////////////////////////////////////////////////
// Instruction-level reference model of the reduced F100-L.
// Include inside the testbench module. Runs an image loaded
// at address 0 and returns each store with the cr seen at
// it, and the final accum, cr and halt.
////////////////////////////////////////////////////////////

`ifndef F100L_TB_MODEL_SVH
`define F100L_TB_MODEL_SVH

function automatic void f100l_model_run(
  input  f100l_pkg::word_t image[],
  input  int               max_steps,
  output f100l_pkg::word_t store_addr[$],
  output f100l_pkg::word_t store_data[$],
  output f100l_pkg::word_t store_cr[$],
  output f100l_pkg::word_t acc,
  output f100l_pkg::word_t cr,
  output bit               halted
);
  f100l_pkg::word_t  mem [f100l_pkg::ram_depth];
  f100l_pkg::instr_t ir;
  f100l_pkg::word_t  pc;
  f100l_pkg::word_t  ea;
  f100l_pkg::word_t  opnd;
  int                sum;
  int                ssum;
  int                steps;

  foreach (mem[i]) mem[i] = '0;
  foreach (image[i]) mem[i] = image[i];
  store_addr.delete();
  store_data.delete();
  store_cr.delete();
  pc = '0;
  acc = '0;
  cr = '0;
  halted = 1'b0;
  steps = 0;
  while (!halted && steps < max_steps)
  begin
    ir = mem[pc[f100l_pkg::ram_addr_width-1:0]];
    pc = pc + 1'b1;
    steps++;
    if (ir.ctrl_form.group == f100l_pkg::halt_group)
      halted = 1'b1;
    else if (!ir.alu_form.indirect &&
             ir.alu_form.op inside {f100l_pkg::op_lda, f100l_pkg::op_sto, f100l_pkg::op_add,
                                    f100l_pkg::op_sub, f100l_pkg::op_and, f100l_pkg::op_neq,
                                    f100l_pkg::op_jmp})
    begin
      if (ir.alu_form.addr == '0)
      begin
        ea = pc;
        pc = pc + 1'b1;
      end
      else
        ea = f100l_pkg::word_t'(ir.alu_form.addr);
      opnd = mem[ea[f100l_pkg::ram_addr_width-1:0]];
      case (ir.alu_form.op)
        f100l_pkg::op_sto:
        begin
          mem[ea[f100l_pkg::ram_addr_width-1:0]] = acc;
          store_addr.push_back(ea);
          store_data.push_back(acc);
          store_cr.push_back(cr);
        end
        f100l_pkg::op_jmp:
          pc = (ir.alu_form.addr == '0) ? opnd : ea;
        default:
        begin
          // Unsigned sum gives carry or borrow, signed sum gives overflow
          case (ir.alu_form.op)
            f100l_pkg::op_add:
            begin
              sum  = int'(opnd) + int'(acc);
              ssum = int'($signed(opnd)) + int'($signed(acc));
            end
            f100l_pkg::op_sub:
            begin
              sum  = int'(opnd) - int'(acc);
              ssum = int'($signed(opnd)) - int'($signed(acc));
            end
            f100l_pkg::op_and: sum = int'(opnd & acc);
            f100l_pkg::op_neq: sum = int'(opnd ^ acc);
            default:           sum = int'(opnd);
          endcase
          if (ir.alu_form.op inside {f100l_pkg::op_add, f100l_pkg::op_sub})
            cr[f100l_pkg::flag_v_bit] = (ssum > 32767) || (ssum < -32768);
          cr[f100l_pkg::flag_c_bit] = (sum < 0) || (sum > 65535);
          acc = f100l_pkg::word_t'(sum);
          cr[f100l_pkg::flag_s_bit] = acc[15];
          cr[f100l_pkg::flag_z_bit] = (acc == '0);
        end
      endcase
    end
  end
endfunction

`endif

//--- testbench/f100l_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the reduced F100-L core.
// Assembles small programs, loads them through the load port
// during reset, runs until halted and checks stores, accum
// and cr against the instruction-level reference model.
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module f100l_tb;

  localparam int clk_period       = 20;
  localparam int reset_cycles     = 3;
  localparam int img_len          = 80;
  localparam int data_base        = 'h40;
  localparam int data_words       = 16;
  localparam int random_programs  = 10;
  localparam int num_tests        = 5 + random_programs;
  localparam int halt_limit       = img_len * 8;
  localparam int post_halt_cycles = 16;
  localparam int model_steps      = 200;

  logic             raw_clk;
  logic             button_reset;
  logic             load_strobe;
  f100l_pkg::word_t load_address;
  f100l_pkg::word_t load_data;
  logic             store_strobe;
  f100l_pkg::word_t store_address;
  f100l_pkg::word_t store_data;
  f100l_pkg::word_t accum;
  f100l_pkg::word_t cr;
  logic             halted;

  f100l_pkg::word_t image [];
  int               wp;
  logic             logging;
  f100l_pkg::word_t got_addr [$];
  f100l_pkg::word_t got_data [$];
  f100l_pkg::word_t got_cr [$];
  int               passed;
  int               failed;

  `include "f100l_tb_model.svh"

  f100l_top f100l_top_i (
    .raw_clk       (raw_clk),
    .button_reset  (button_reset),
    .load_strobe   (load_strobe),
    .load_address  (load_address),
    .load_data     (load_data),
    .store_strobe  (store_strobe),
    .store_address (store_address),
    .store_data    (store_data),
    .accum         (accum),
    .cr            (cr),
    .halted        (halted)
  );

  initial
  begin
    raw_clk = 1'b0;
    forever #(clk_period / 2) raw_clk = ~raw_clk;
  end

  // Capture every store in the middle of its cycle, with the flags of the op before it
  always @(negedge raw_clk)
  begin
    if (logging && store_strobe === 1'b1)
    begin
      got_addr.push_back(store_address);
      got_data.push_back(store_data);
      got_cr.push_back(cr);
    end
  end

  initial
  begin
    #(num_tests * img_len * 8 * clk_period);
    $display("Watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

  // Program image helpers, random filler everywhere first
  function automatic void start_image();
    image = new[img_len];
    foreach (image[i])
      image[i] = f100l_pkg::word_t'($urandom);
    wp = 0;
  endfunction

  function automatic void emit(input f100l_pkg::word_t w);
    image[wp] = w;
    wp++;
  endfunction

  function automatic void emit_short(input f100l_pkg::op_t op, input int n);
    f100l_pkg::instr_t w;
    w.alu_form.op       = op;
    w.alu_form.indirect = 1'b0;
    w.alu_form.addr     = n[f100l_pkg::ram_addr_width-1:0];
    emit(w);
  endfunction

  function automatic void emit_imm(input f100l_pkg::op_t op, input f100l_pkg::word_t lit);
    emit_short(op, 0);
    emit(lit);
  endfunction

  function automatic void emit_halt();
    f100l_pkg::instr_t w;
    w = '0;
    w.ctrl_form.group = f100l_pkg::halt_group;
    emit(w);
  endfunction

  function automatic f100l_pkg::op_t op_for(input int k);
    case (k)
      0:       return f100l_pkg::op_lda;
      1:       return f100l_pkg::op_add;
      2:       return f100l_pkg::op_sub;
      3:       return f100l_pkg::op_and;
      default: return f100l_pkg::op_neq;
    endcase
  endfunction

  function automatic void emit_random_instr();
    int pick;
    int n;
    pick = $urandom_range(0, 6);
    n    = data_base + $urandom_range(0, data_words - 1);
    if (pick == 6)
    begin
      // Forward jump over one store
      emit_short(f100l_pkg::op_jmp, wp + 2);
      emit_short(f100l_pkg::op_sto, n);
    end
    else if (pick == 5)
      emit_short(f100l_pkg::op_sto, n);
    else if ($urandom_range(0, 1) == 1)
      emit_imm(op_for(pick), f100l_pkg::word_t'($urandom));
    else
      emit_short(op_for(pick), n);
  endfunction

  task automatic load_and_release();
    @(posedge raw_clk);
    #2;
    button_reset = 1'b0;
    logging      = 1'b0;
    for (int a = 0; a < img_len; a++)
    begin
      load_strobe  = 1'b1;
      load_address = f100l_pkg::word_t'(a);
      load_data    = image[a];
      @(posedge raw_clk);
      #2;
    end
    load_strobe = 1'b0;
    repeat (reset_cycles) @(posedge raw_clk);
    #2;
    got_addr.delete();
    got_data.delete();
    got_cr.delete();
    logging      = 1'b1;
    button_reset = 1'b1;
  endtask

  task automatic run_test(input string name);
    f100l_pkg::word_t exp_addr [$];
    f100l_pkg::word_t exp_data [$];
    f100l_pkg::word_t exp_st_cr [$];
    f100l_pkg::word_t exp_acc;
    f100l_pkg::word_t exp_cr;
    bit               exp_halted;
    int               errs;
    int               cycles;
    int               stores_at_halt;
    bit               halt_dropped;

    errs = 0;
    load_and_release();
    @(negedge raw_clk);
    if (halted !== 1'b0)
    begin
      $display("%s: halted was still high after reset", name);
      errs++;
    end
    cycles = 0;
    while (halted !== 1'b1 && cycles < halt_limit)
    begin
      @(negedge raw_clk);
      cycles++;
    end
    if (halted !== 1'b1)
    begin
      $display("%s: core did not halt within %0d cycles", name, halt_limit);
      errs++;
    end
    stores_at_halt = got_addr.size();
    halt_dropped   = 1'b0;
    repeat (post_halt_cycles)
    begin
      @(negedge raw_clk);
      if (halted !== 1'b1)
        halt_dropped = 1'b1;
    end
    if (halt_dropped)
    begin
      $display("%s: halted dropped while reset was high", name);
      errs++;
    end
    if (got_addr.size() != stores_at_halt)
    begin
      $display("%s: a store happened after halt", name);
      errs++;
    end
    logging = 1'b0;

    f100l_model_run(image, model_steps, exp_addr, exp_data, exp_st_cr, exp_acc, exp_cr,
                    exp_halted);
    if (!exp_halted)
    begin
      $display("%s: reference model did not reach a halt", name);
      errs++;
    end
    if (got_addr.size() != exp_addr.size())
    begin
      $display("Fail %s: store count got 0x%0h expected 0x%0h",
               name, got_addr.size(), exp_addr.size());
      errs++;
    end
    else
    begin
      foreach (exp_addr[i])
      begin
        if (got_addr[i] !== exp_addr[i])
        begin
          $display("Fail %s: store_address[%0d] got 0x%04h expected 0x%04h",
                   name, i, got_addr[i], exp_addr[i]);
          errs++;
        end
        if (got_data[i] !== exp_data[i])
        begin
          $display("Fail %s: store_data[%0d] got 0x%04h expected 0x%04h",
                   name, i, got_data[i], exp_data[i]);
          errs++;
        end
        if (got_cr[i] !== exp_st_cr[i])
        begin
          $display("Fail %s: cr at store[%0d] got 0x%04h expected 0x%04h",
                   name, i, got_cr[i], exp_st_cr[i]);
          errs++;
        end
      end
    end
    if (accum !== exp_acc)
    begin
      $display("Fail %s: accum got 0x%04h expected 0x%04h", name, accum, exp_acc);
      errs++;
    end
    if (cr !== exp_cr)
    begin
      $display("Fail %s: cr got 0x%04h expected 0x%04h", name, cr, exp_cr);
      errs++;
    end

    if (errs == 0)
    begin
      $display("Test %s: ok, %0d stores", name, exp_addr.size());
      passed++;
    end
    else
    begin
      $display("Test %s: %0d errors", name, errs);
      failed++;
    end
  endtask

  initial
  begin
    button_reset = 1'b0;
    load_strobe  = 1'b0;
    load_address = '0;
    load_data    = '0;
    logging      = 1'b0;
    passed       = 0;
    failed       = 0;
    void'($urandom(55));

    start_image();
    emit_imm(f100l_pkg::op_lda, 16'h0000);
    emit_short(f100l_pkg::op_sto, data_base);
    emit_imm(f100l_pkg::op_lda, f100l_pkg::word_t'($urandom) | 16'h8000);
    emit_short(f100l_pkg::op_sto, data_base + 1);
    emit_halt();
    run_test("lda_sto");

    // Overflow, carry, borrow and random add and subtract
    start_image();
    emit_imm(f100l_pkg::op_lda, 16'h7fff);
    emit_imm(f100l_pkg::op_add, 16'h0001);
    emit_short(f100l_pkg::op_sto, data_base);
    emit_imm(f100l_pkg::op_lda, 16'hffff);
    emit_imm(f100l_pkg::op_add, 16'h0001);
    emit_short(f100l_pkg::op_sto, data_base + 1);
    emit_imm(f100l_pkg::op_lda, 16'h0001);
    emit_imm(f100l_pkg::op_sub, 16'h0000);
    emit_short(f100l_pkg::op_sto, data_base + 2);
    emit_imm(f100l_pkg::op_lda, f100l_pkg::word_t'($urandom));
    emit_short(f100l_pkg::op_add, data_base + 5);
    emit_short(f100l_pkg::op_sto, data_base + 3);
    emit_imm(f100l_pkg::op_lda, f100l_pkg::word_t'($urandom));
    emit_short(f100l_pkg::op_sub, data_base + 6);
    emit_short(f100l_pkg::op_sto, data_base + 4);
    emit_imm(f100l_pkg::op_lda, 16'h0001);
    emit_imm(f100l_pkg::op_sub, 16'h8000);
    emit_halt();
    run_test("add_sub");

    // C and V both set before the logic ops
    start_image();
    emit_imm(f100l_pkg::op_lda, 16'hffff);
    emit_imm(f100l_pkg::op_add, 16'h8000);
    emit_imm(f100l_pkg::op_and, f100l_pkg::word_t'($urandom));
    emit_short(f100l_pkg::op_sto, data_base);
    emit_short(f100l_pkg::op_neq, data_base + 3);
    emit_short(f100l_pkg::op_sto, data_base + 1);
    emit_halt();
    run_test("and_neq");

    start_image();
    emit_imm(f100l_pkg::op_lda, f100l_pkg::word_t'($urandom));
    emit_short(f100l_pkg::op_jmp, wp + 2);
    emit_short(f100l_pkg::op_sto, data_base);
    emit_short(f100l_pkg::op_sto, data_base + 1);
    emit_imm(f100l_pkg::op_jmp, f100l_pkg::word_t'(wp + 3));
    emit_short(f100l_pkg::op_sto, data_base + 2);
    emit_short(f100l_pkg::op_sto, data_base + 3);
    emit_halt();
    run_test("jmp");

    start_image();
    emit_imm(f100l_pkg::op_lda, f100l_pkg::word_t'($urandom));
    emit_short(f100l_pkg::op_sto, data_base);
    emit_halt();
    emit_short(f100l_pkg::op_sto, data_base + 1);
    emit_short(f100l_pkg::op_sto, data_base + 2);
    run_test("halt");

    for (int k = 0; k < random_programs; k++)
    begin
      start_image();
      repeat (12) emit_random_instr();
      emit_halt();
      run_test($sformatf("random_%0d", k));
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
    if (failed == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- f100l_top.f
+incdir+include
source/f100l_pkg.sv
source/mem_bus_if.sv
source/f100l_alu.sv
source/f100l_ram.sv
source/f100l_sequencer.sv
source/f100l_top.sv
testbench/f100l_tb.sv

//--- Bender.yml
package:
  name: f100l

sources:
  - include_dirs:
      - include
    files:
      - source/f100l_pkg.sv
      - source/mem_bus_if.sv
      - source/f100l_alu.sv
      - source/f100l_ram.sv
      - source/f100l_sequencer.sv
      - source/f100l_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/f100l_tb.sv
